/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_axil_register_subsystem
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Simulation finished: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BINARY)

# Rebuilt only when a source or the file list changes
$(BUILD_DIR)/V%: $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$*

run: $(BINARY)
	@out="$$(./$(BINARY))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* sim.f */
verilog/axil_regs_pkg.sv
verilog/axil_skid_buffer.sv
verilog/axil_register_frontend.sv
verilog/read_delay_timer.sv
verilog/register_bank.sv
verilog/axil_register_subsystem.sv
verif/tb_axil_register_subsystem.sv

/* verif/tb_axil_register_subsystem.sv */
`timescale 1ns/1ns

module tb_axil_register_subsystem import axil_regs_pkg::*; #(
    parameter addr_t BASE_ADDRESS = 32'h0000_4000,
    parameter int NUM_REGISTERS = 16,
    parameter int READ_DELAY = 2,
    parameter bit REGISTERED_BUFFERS = 1'b0
);

    localparam int TIMEOUT_CYCLES = 200;
    localparam int NUM_STEPS = 400;
    localparam logic [31:0] SEED = 32'h60c7_1c81;

    logic  clock;
    logic  reset;
    addr_t awaddr;
    logic  awvalid;
    logic  awready;
    data_t wdata;
    strb_t wstrb;
    logic  wvalid;
    logic  wready;
    resp_t bresp;
    logic  bvalid;
    logic  bready = 1'b0;
    addr_t araddr;
    logic  arvalid;
    logic  arready;
    data_t rdata;
    resp_t rresp;
    logic  rvalid;
    logic  rready = 1'b0;

    // Reference copy of the register contents
    data_t  model [NUM_REGISTERS];
    data_t  expected_rdata;
    string  test_name;
    integer seed;
    integer ready_seed;
    int     b_stall;
    int     r_stall;
    int     b_count;
    int     r_count;
    int     writes_sent;
    int     reads_sent;
    int     value_errors;
    int     timeout_errors;
    int     protocol_errors;

    axil_register_subsystem #(
        .BASE_ADDRESS(BASE_ADDRESS),
        .NUM_REGISTERS(NUM_REGISTERS),
        .READ_DELAY(READ_DELAY),
        .REGISTERED_BUFFERS(REGISTERED_BUFFERS)
    ) dut0 (
        .clock(clock),
        .reset(reset),
        .awaddr(awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata(wdata),
        .wstrb(wstrb),
        .wvalid(wvalid),
        .wready(wready),
        .bresp(bresp),
        .bvalid(bvalid),
        .bready(bready),
        .araddr(araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata(rdata),
        .rresp(rresp),
        .rvalid(rvalid),
        .rready(rready)
    );

    always #4 clock = ~clock;

    function automatic int random_below(input int limit);
        return int'($unsigned($random(seed)) % limit);
    endfunction

    // Byte lane mask built from the strobes
    function automatic data_t apply_strobes(input data_t old_word, input data_t new_word,
                                            input strb_t strb);
        data_t mask;
        for (int b = 0; b < STRB_WIDTH; b++) begin
            mask[b*8 +: 8] = {8{strb[b]}};
        end
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    task automatic check_data(input string name, input data_t expected, input data_t actual);
        if (expected !== actual) begin
            value_errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_resp(input string name, input resp_t expected, input resp_t actual);
        if (expected !== actual) begin
            value_errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Random back-pressure on B and R, with occasional longer stalls
    always @(negedge clock) begin
        if (!reset) begin
            bready = 1'b0;
            rready = 1'b0;
        end else begin
            if (b_stall > 0) begin
                b_stall = b_stall - 1;
                bready = 1'b0;
            end else if (($random(ready_seed) & 7) == 0) begin
                b_stall = 2 + ($random(ready_seed) & 3);
                bready = 1'b0;
            end else begin
                bready = ($random(ready_seed) & 3) != 0;
            end
            if (r_stall > 0) begin
                r_stall = r_stall - 1;
                rready = 1'b0;
            end else if (($random(ready_seed) & 7) == 0) begin
                r_stall = 2 + ($random(ready_seed) & 3);
                rready = 1'b0;
            end else begin
                rready = ($random(ready_seed) & 3) != 0;
            end
            // Both high now, so the transfer happens at the next rising edge
            if (bvalid && bready) begin
                b_count++;
                check_resp({test_name, " bresp"}, resp_okay, bresp);
            end
            if (rvalid && rready) begin
                r_count++;
                check_data({test_name, " rdata"}, expected_rdata, rdata);
                check_resp({test_name, " rresp"}, resp_okay, rresp);
            end
        end
    end

    // Hold the selected valids until each one has been accepted
    task automatic push_write(input logic send_aw, input logic send_w);
        int   waited;
        logic aw_left;
        logic w_left;
        waited = 0;
        aw_left = send_aw;
        w_left = send_w;
        awvalid = send_aw;
        wvalid = send_w;
        while ((aw_left || w_left) && waited < TIMEOUT_CYCLES) begin
            if (awvalid && awready) begin
                aw_left = 1'b0;
            end
            if (wvalid && wready) begin
                w_left = 1'b0;
            end
            @(negedge clock);
            waited++;
            if (!aw_left) begin
                awvalid = 1'b0;
            end
            if (!w_left) begin
                wvalid = 1'b0;
            end
        end
        if (aw_left || w_left) begin
            timeout_errors++;
            $display("%s: write address or data was never accepted", test_name);
            awvalid = 1'b0;
            wvalid = 1'b0;
        end
    endtask

    task automatic push_read();
        int waited;
        waited = 0;
        arvalid = 1'b1;
        while (!arready && waited < TIMEOUT_CYCLES) begin
            @(negedge clock);
            waited++;
        end
        if (!arready) begin
            timeout_errors++;
            $display("%s: read address was never accepted", test_name);
        end
        @(negedge clock);
        arvalid = 1'b0;
    endtask

    task automatic wait_responses();
        int waited;
        waited = 0;
        while ((b_count < writes_sent || r_count < reads_sent) && waited < TIMEOUT_CYCLES) begin
            @(posedge clock);
            waited++;
        end
        if (b_count < writes_sent || r_count < reads_sent) begin
            timeout_errors++;
            $display("%s: no response within %0d cycles", test_name, TIMEOUT_CYCLES);
        end
        @(negedge clock);
    endtask

    task automatic write_register(input reg_index_t index, input data_t data, input strb_t strb);
        int order;
        int gap;
        int b_before;
        order = random_below(3);
        gap = random_below(4);
        b_before = b_count;
        awaddr = BASE_ADDRESS + (index << 2);
        wdata = data;
        wstrb = strb;
        if (order == 2) begin
            push_write(1'b1, 1'b1);
        end else begin
            // One channel alone must not complete the write
            push_write(order == 0, order == 1);
            repeat (gap) @(negedge clock);
            if (bvalid || b_count != b_before) begin
                protocol_errors++;
                $display("%s: write response came before address and data both arrived",
                         test_name);
            end
            push_write(order == 1, order == 0);
        end
        writes_sent++;
        if (index < reg_index_t'(NUM_REGISTERS)) begin
            model[index] = apply_strobes(model[index], data, strb);
        end
        wait_responses();
    endtask

    task automatic read_register(input reg_index_t index);
        if (index < reg_index_t'(NUM_REGISTERS)) begin
            expected_rdata = model[index];
        end else begin
            expected_rdata = '0;
        end
        araddr = BASE_ADDRESS + (index << 2);
        push_read();
        reads_sent++;
        wait_responses();
    endtask

    initial begin
        reg_index_t index;
        seed = SEED;
        ready_seed = ~SEED;
        clock = 1'b0;
        reset = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        expected_rdata = '0;
        test_name = "reset";
        b_stall = 0;
        r_stall = 0;
        b_count = 0;
        r_count = 0;
        writes_sent = 0;
        reads_sent = 0;
        value_errors = 0;
        timeout_errors = 0;
        protocol_errors = 0;
        for (int i = 0; i < NUM_REGISTERS; i++) begin
            model[i] = '0;
        end
        repeat (5) @(negedge clock);
        reset = 1'b1;
        @(negedge clock);

        test_name = "reset_values";
        for (int i = 0; i < NUM_REGISTERS; i++) begin
            read_register(reg_index_t'(i));
        end

        test_name = "full_strobe";
        repeat (8) begin
            index = reg_index_t'(random_below(NUM_REGISTERS));
            write_register(index, data_t'($random(seed)), 4'hf);
            read_register(index);
        end

        // Mixed traffic including out-of-range indices and partial strobes
        test_name = "random_traffic";
        repeat (NUM_STEPS) begin
            index = reg_index_t'(random_below(NUM_REGISTERS + 4));
            if (random_below(2) == 0) begin
                write_register(index, data_t'($random(seed)), strb_t'($random(seed)));
            end else begin
                read_register(index);
            end
        end

        test_name = "final_sweep";
        for (int i = 0; i < NUM_REGISTERS + 4; i++) begin
            read_register(reg_index_t'(i));
        end

        if (b_count != writes_sent || r_count != reads_sent) begin
            protocol_errors++;
            $display("Response count wrong: %0d writes got %0d B, %0d reads got %0d R",
                     writes_sent, b_count, reads_sent, r_count);
        end
        $display("Errors: %0d value, %0d timeout, %0d protocol",
                 value_errors, timeout_errors, protocol_errors);
        if (value_errors == 0 && timeout_errors == 0 && protocol_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* verilog/axil_register_frontend.sv */
`timescale 1ns/1ns

module axil_register_frontend import axil_regs_pkg::*; #(
    parameter addr_t BASE_ADDRESS = '0,
    parameter bit REGISTERED_BUFFERS = 1'b0
) (
    input  logic       clock,
    input  logic       reset,
    // AXI4-Lite slave
    input  addr_t      awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  data_t      wdata,
    input  strb_t      wstrb,
    input  logic       wvalid,
    output logic       wready,
    output resp_t      bresp,
    output logic       bvalid,
    input  logic       bready,
    input  addr_t      araddr,
    input  logic       arvalid,
    output logic       arready,
    output data_t      rdata,
    output resp_t      rresp,
    output logic       rvalid,
    input  logic       rready,
    // Register bank side
    output logic       wr_en,
    output reg_index_t wr_index,
    output data_t      wr_data,
    output strb_t      wr_strb,
    output logic       rd_req_valid,
    output reg_index_t rd_req_index,
    input  logic       rd_req_ready,
    input  logic       rd_data_valid,
    input  data_t      rd_data
);

    addr_t          aw_out_addr;
    logic           aw_out_valid;
    write_payload_t w_in_payload;
    write_payload_t w_out_payload;
    logic           w_out_valid;
    addr_t          ar_out_addr;
    logic           ar_out_valid;
    logic           write_fire;
    logic           read_fire;
    logic           read_pending;

    axil_skid_buffer #(
        .payload_t(addr_t),
        .REGISTER_OUTPUT(REGISTERED_BUFFERS)
    ) aw_buffer (
        .clock(clock),
        .reset(reset),
        .in_valid(awvalid),
        .in_ready(awready),
        .in_data(awaddr),
        .out_valid(aw_out_valid),
        .out_ready(write_fire),
        .out_data(aw_out_addr)
    );

    assign w_in_payload.data = wdata;
    assign w_in_payload.strb = wstrb;

    axil_skid_buffer #(
        .payload_t(write_payload_t),
        .REGISTER_OUTPUT(REGISTERED_BUFFERS)
    ) w_buffer (
        .clock(clock),
        .reset(reset),
        .in_valid(wvalid),
        .in_ready(wready),
        .in_data(w_in_payload),
        .out_valid(w_out_valid),
        .out_ready(write_fire),
        .out_data(w_out_payload)
    );

    axil_skid_buffer #(
        .payload_t(addr_t),
        .REGISTER_OUTPUT(REGISTERED_BUFFERS)
    ) ar_buffer (
        .clock(clock),
        .reset(reset),
        .in_valid(arvalid),
        .in_ready(arready),
        .in_data(araddr),
        .out_valid(ar_out_valid),
        .out_ready(read_fire),
        .out_data(ar_out_addr)
    );

    // Write needs address, data and room for the B response
    assign write_fire = aw_out_valid && w_out_valid && (!bvalid || bready);

    assign wr_en = write_fire;
    assign wr_index = (aw_out_addr - BASE_ADDRESS) >> 2;
    assign wr_data = w_out_payload.data;
    assign wr_strb = w_out_payload.strb;

    always_ff @(posedge clock) begin
        if (!reset) begin
            bvalid <= 1'b0;
        end else if (write_fire) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    assign bresp = resp_okay;

    // One read at a time, and only when R can take the result
    assign rd_req_valid = ar_out_valid && !read_pending && (!rvalid || rready);
    assign rd_req_index = (ar_out_addr - BASE_ADDRESS) >> 2;
    assign read_fire = rd_req_valid && rd_req_ready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            read_pending <= 1'b0;
        end else if (read_fire) begin
            read_pending <= 1'b1;
        end else if (rd_data_valid) begin
            read_pending <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            rvalid <= 1'b0;
        end else if (rd_data_valid) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (rd_data_valid) begin
            rdata <= rd_data;
        end
    end

    assign rresp = resp_okay;

    // Bank must only answer a request this unit issued
    no_unsolicited_read: assert property (@(posedge clock) disable iff (!reset)
        rd_data_valid |-> read_pending);

endmodule

/* verilog/axil_register_subsystem.sv */
`timescale 1ns/1ns

module axil_register_subsystem import axil_regs_pkg::*; #(
    parameter addr_t BASE_ADDRESS = '0,
    parameter int NUM_REGISTERS = 16,
    parameter int READ_DELAY = 2,
    parameter bit REGISTERED_BUFFERS = 1'b0
) (
    input  logic  clock,
    input  logic  reset,
    input  addr_t awaddr,
    input  logic  awvalid,
    output logic  awready,
    input  data_t wdata,
    input  strb_t wstrb,
    input  logic  wvalid,
    output logic  wready,
    output resp_t bresp,
    output logic  bvalid,
    input  logic  bready,
    input  addr_t araddr,
    input  logic  arvalid,
    output logic  arready,
    output data_t rdata,
    output resp_t rresp,
    output logic  rvalid,
    input  logic  rready
);

    // Front end to bank
    logic       wr_en;
    reg_index_t wr_index;
    data_t      wr_data;
    strb_t      wr_strb;
    logic       rd_req_valid;
    reg_index_t rd_req_index;
    logic       rd_req_ready;
    logic       rd_data_valid;
    data_t      rd_data;

    axil_register_frontend #(
        .BASE_ADDRESS(BASE_ADDRESS),
        .REGISTERED_BUFFERS(REGISTERED_BUFFERS)
    ) frontend (
        .clock(clock),
        .reset(reset),
        .awaddr(awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata(wdata),
        .wstrb(wstrb),
        .wvalid(wvalid),
        .wready(wready),
        .bresp(bresp),
        .bvalid(bvalid),
        .bready(bready),
        .araddr(araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata(rdata),
        .rresp(rresp),
        .rvalid(rvalid),
        .rready(rready),
        .wr_en(wr_en),
        .wr_index(wr_index),
        .wr_data(wr_data),
        .wr_strb(wr_strb),
        .rd_req_valid(rd_req_valid),
        .rd_req_index(rd_req_index),
        .rd_req_ready(rd_req_ready),
        .rd_data_valid(rd_data_valid),
        .rd_data(rd_data)
    );

    register_bank #(
        .NUM_REGISTERS(NUM_REGISTERS),
        .READ_DELAY(READ_DELAY)
    ) bank (
        .clock(clock),
        .reset(reset),
        .wr_en(wr_en),
        .wr_index(wr_index),
        .wr_data(wr_data),
        .wr_strb(wr_strb),
        .rd_req_valid(rd_req_valid),
        .rd_req_index(rd_req_index),
        .rd_req_ready(rd_req_ready),
        .rd_data_valid(rd_data_valid),
        .rd_data(rd_data)
    );

endmodule

/* verilog/axil_regs_pkg.sv */
package axil_regs_pkg;

    // Bus geometry
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int RESP_WIDTH = 2;
    localparam int INDEX_WIDTH = 32;

    // Byte address as seen on the AXI bus
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // One register word
    typedef logic [DATA_WIDTH-1:0] data_t;

    // One strobe bit per data byte
    typedef logic [STRB_WIDTH-1:0] strb_t;

    typedef logic [RESP_WIDTH-1:0] resp_t;

    // Only OKAY is ever returned
    localparam resp_t resp_okay = 2'b00;

    // Register index after base removal and word shift
    typedef logic [INDEX_WIDTH-1:0] reg_index_t;

    // W channel payload carried through the skid buffer
    typedef struct packed {
        data_t data;
        strb_t strb;
    } write_payload_t;

endpackage

/* verilog/axil_skid_buffer.sv */
`timescale 1ns/1ns

module axil_skid_buffer #(
    parameter type payload_t = logic [31:0],
    parameter bit REGISTER_OUTPUT = 1'b0
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     active;
    logic     skid_valid;
    payload_t skid_data;
    logic     in_fire;

    // Ready stays low until the first cycle out of reset
    always_ff @(posedge clock) begin
        if (!reset) begin
            active <= 1'b0;
        end else begin
            active <= 1'b1;
        end
    end

    // Registered ready, no path from out_ready
    assign in_ready = active && !skid_valid;
    assign in_fire = in_valid && in_ready;

    generate
        if (REGISTER_OUTPUT) begin : g_registered
            logic     out_valid_q;
            payload_t out_data_q;
            logic     out_load;

            // Output stage can take a new item
            assign out_load = !out_valid_q || out_ready;

            always_ff @(posedge clock) begin
                if (!reset) begin
                    out_valid_q <= 1'b0;
                    skid_valid <= 1'b0;
                end else if (out_load) begin
                    if (skid_valid) begin
                        // Drain the skid entry first
                        out_valid_q <= 1'b1;
                        skid_valid <= 1'b0;
                    end else begin
                        out_valid_q <= in_fire;
                    end
                end else if (in_fire) begin
                    skid_valid <= 1'b1;
                end
            end

            always_ff @(posedge clock) begin
                if (out_load) begin
                    out_data_q <= skid_valid ? skid_data : in_data;
                end
                if (!out_load && in_fire) begin
                    skid_data <= in_data;
                end
            end

            assign out_valid = out_valid_q;
            assign out_data = out_data_q;
        end else begin : g_bypass
            // Input passes straight through while the skid entry is empty
            assign out_valid = skid_valid || in_fire;
            assign out_data = skid_valid ? skid_data : in_data;

            always_ff @(posedge clock) begin
                if (!reset) begin
                    skid_valid <= 1'b0;
                end else if (skid_valid) begin
                    if (out_ready) begin
                        skid_valid <= 1'b0;
                    end
                end else if (in_fire && !out_ready) begin
                    skid_valid <= 1'b1;
                end
            end

            always_ff @(posedge clock) begin
                if (in_fire && !out_ready) begin
                    skid_data <= in_data;
                end
            end
        end
    endgenerate

    // A stalled output item must not change under the consumer
    out_data_hold: assert property (@(posedge clock) disable iff (!reset)
        out_valid && !out_ready |=> $stable(out_data));

endmodule

/* verilog/read_delay_timer.sv */
`timescale 1ns/1ns

module read_delay_timer import axil_regs_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       start,
    input  reg_index_t count,
    output logic       busy,
    output logic       done
);

    reg_index_t remaining;

    // Expires when the loaded count has run down
    assign done = busy && (remaining == '0);

    always_ff @(posedge clock) begin
        if (!reset) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            remaining <= count;
        end else if (busy && remaining != '0) begin
            remaining <= remaining - 1;
        end
    end

    // Only one access delay may run at a time
    no_restart_while_busy: assert property (@(posedge clock) disable iff (!reset)
        start |-> !busy);

endmodule

/* verilog/register_bank.sv */
`timescale 1ns/1ns

module register_bank import axil_regs_pkg::*; #(
    parameter int NUM_REGISTERS = 16,
    parameter int READ_DELAY = 2
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       wr_en,
    input  reg_index_t wr_index,
    input  data_t      wr_data,
    input  strb_t      wr_strb,
    input  logic       rd_req_valid,
    input  reg_index_t rd_req_index,
    output logic       rd_req_ready,
    output logic       rd_data_valid,
    output data_t      rd_data
);

    localparam int INDEX_BITS = (NUM_REGISTERS > 1) ? $clog2(NUM_REGISTERS) : 1;

    data_t      registers [NUM_REGISTERS];
    reg_index_t read_index;
    logic       read_start;
    logic       timer_busy;
    logic       timer_done;
    logic       write_hit;
    logic       read_hit;

    // Merge new bytes over the old word where the strobe is set
    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input strb_t strb);
        data_t result;
        result = old_word;
        for (int b = 0; b < STRB_WIDTH; b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    assign write_hit = wr_en && (wr_index < reg_index_t'(NUM_REGISTERS));

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < NUM_REGISTERS; i++) begin
                registers[i] <= '0;
            end
        end else if (write_hit) begin
            registers[wr_index[INDEX_BITS-1:0]] <=
                merge_bytes(registers[wr_index[INDEX_BITS-1:0]], wr_data, wr_strb);
        end
    end

    // Accept a read only while no delay is running
    assign rd_req_ready = !timer_busy;
    assign read_start = rd_req_valid && rd_req_ready;

    always_ff @(posedge clock) begin
        if (read_start) begin
            read_index <= rd_req_index;
        end
    end

    read_delay_timer delay_timer (
        .clock(clock),
        .reset(reset),
        .start(read_start),
        .count(reg_index_t'(READ_DELAY)),
        .busy(timer_busy),
        .done(timer_done)
    );

    // Value is sampled at the end of the delay, so late writes show up
    assign read_hit = read_index < reg_index_t'(NUM_REGISTERS);
    assign rd_data_valid = timer_done;
    assign rd_data = read_hit ? registers[read_index[INDEX_BITS-1:0]] : '0;

endmodule
